// File: files.f
chroma_dc_pkg.sv
qs_if.sv
derr_if.sv
quantize_single.sv
derr_line_buffer.sv
dc_error_corrector.sv
chroma_dc_quant_top.sv
chroma_dc_quant_sva.sv
tb_chroma_dc_quant.sv

// File: Makefile
# Verilator flow for the chroma DC quantizer: lint, simulate, clean

VERILATOR  ?= verilator
FILELIST   ?= files.f
TB_TOP     ?= tb_chroma_dc_quant
RTL_TOP    ?= chroma_dc_quant_top
OBJ_DIR    ?= obj_dir
SIM_BIN    ?= sim_$(TB_TOP)
LOG        ?= sim.log
PASS_MSG   ?= test passed
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(OBJ_DIR) -o $(SIM_BIN)
	./$(OBJ_DIR)/$(SIM_BIN) $(SIM_ARGS) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_chroma_dc_quant.sv
// Testbench for the chroma DC quantizer against a reference model of quantizing and diffusion
`timescale 1ns/1ns

module tb_chroma_dc_quant
    import chroma_dc_pkg::*;
();

    localparam int I_W   = 12;
    localparam int O_W   = 16;
    localparam int C_W   = 10;
    localparam int Q     = 24;
    localparam int IQ    = 5461;
    localparam int BIAS  = 49152;
    localparam int ZTH   = 20;
    localparam int NBLK  = 16;
    localparam int LIMIT = NBLK * 12 + 200;

    logic               clk;
    logic               rst_n;
    logic               blk_valid;
    logic [C_W-1:0]     blk_x;
    logic [C_W-1:0]     blk_y;
    logic [8*I_W-1:0]   blk_coef;
    logic               credit;
    logic [8*O_W-1:0]   levels;
    logic [6*ERR_W-1:0] derr;
    logic               done;

    int seed;
    int errors;
    int checks;
    int cycles;
    int coef [8];
    // Bottom row errors per column and right column error per plane
    int top_err [4][4];
    int left_err [2];

    chroma_dc_quant_top #(
        .I_WIDTH (I_W),
        .O_WIDTH (O_W),
        .COL_W   (C_W)
    ) u_chroma_dc_quant_top (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_valid_i (blk_valid),
        .blk_x_i     (blk_x),
        .blk_y_i     (blk_y),
        .blk_coef_i  (blk_coef),
        .q_i         (Q_W'(Q)),
        .iq_i        (Q_W'(IQ)),
        .bias_i      (B_W'(BIAS)),
        .zthresh_i   (B_W'(ZTH)),
        .credit_o    (credit),
        .levels_o    (levels),
        .derr_o      (derr),
        .done_o      (done)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int diffused_input(input int c, input int t, input int l);
        return c + ((7 * t + 8 * l) >>> 3);
    endfunction

    task automatic ref_quantize(input int v, output int lvl, output int err);
        int mag;
        int lm;
        mag = (v < 0) ? -v : v;
        lm  = 0;
        if (mag > ZTH) begin
            lm = ((mag * IQ + BIAS) >>> QFIX) * Q;
        end
        lvl = (v < 0) ? -lm : lm;
        err = ((v < 0) ? lm - mag : mag - lm) >>> 1;
    endtask

    task automatic predict_block(input int x, input int y, output logic [8*O_W-1:0] lv,
                                 output logic [6*ERR_W-1:0] de);
        int t0;
        int t1;
        int l;
        int e [4];
        int lvl [4];
        for (int p = 0; p < 2; p++) begin
            t0 = (y != 0) ? top_err[x][2*p] : 0;
            t1 = (y != 0) ? top_err[x][2*p+1] : 0;
            l  = (x != 0) ? left_err[p] : 0;
            ref_quantize(diffused_input(coef[4*p], t0, l), lvl[0], e[0]);
            ref_quantize(diffused_input(coef[4*p+1], t1, e[0]), lvl[1], e[1]);
            ref_quantize(diffused_input(coef[4*p+2], e[0], l), lvl[2], e[2]);
            ref_quantize(diffused_input(coef[4*p+3], e[1], e[2]), lvl[3], e[3]);
            for (int k = 0; k < 4; k++) begin
                lv[(4*p+k)*O_W +: O_W] = O_W'(lvl[k]);
            end
            for (int k = 1; k < 4; k++) begin
                de[(3*p+k-1)*ERR_W +: ERR_W] = ERR_W'(e[k]);
            end
            top_err[x][2*p]   = e[2];
            top_err[x][2*p+1] = e[3];
            left_err[p]       = e[3];
        end
    endtask

    // ----------------------------------------
    // Stimulus and checks
    // ----------------------------------------
    task automatic check_value(input string name, input string what,
                               input logic [127:0] expected, input logic [127:0] actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAILED %s %s expected %0h actual %0h", name, what, expected, actual);
        end
    endtask

    task automatic fill_random();
        for (int i = 0; i < 8; i++) begin
            coef[i] = $random(seed) % 200;
        end
    endtask

    task automatic drive_block(input int x, input int y);
        blk_valid = 1'b1;
        blk_x     = C_W'(x);
        blk_y     = C_W'(y);
        for (int i = 0; i < 8; i++) begin
            blk_coef[i*I_W +: I_W] = I_W'(coef[i]);
        end
    endtask

    // Sends one block once the credit is back and checks its result
    task automatic run_block(input string name, input int x, input int y);
        logic [8*O_W-1:0]   exp_lv;
        logic [6*ERR_W-1:0] exp_de;
        int                 lat;
        int                 gap;
        gap = $unsigned($random(seed)) % 3;
        repeat (gap) @(negedge clk);
        @(negedge clk);
        drive_block(x, y);
        predict_block(x, y, exp_lv, exp_de);
        @(negedge clk);
        blk_valid = 1'b0;
        lat = 0;
        while (!done) begin
            @(negedge clk);
            lat++;
        end
        check_value(name, "latency", (y != 0) ? 9 : 7, lat);
        check_value(name, "credit", 1, credit);
        check_value(name, "levels", exp_lv, levels);
        check_value(name, "errors", exp_de, derr);
    endtask

    // Reset lands in the result cycle, before the block writes back
    task automatic abort_block();
        fill_random();
        @(negedge clk);
        drive_block(2, 1);
        @(negedge clk);
        blk_valid = 1'b0;
        while (!done) begin
            @(negedge clk);
        end
        rst_n = 1'b0;
        #1;
        check_value("mid_reset", "done", 0, done);
        check_value("mid_reset", "credit", 0, credit);
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        left_err[0] = 0;
        left_err[1] = 0;
    endtask

    initial begin
        string name;
        int    sva_fails;
        seed      = 32'h9c587d5d;
        errors    = 0;
        checks    = 0;
        rst_n     = 1'b0;
        blk_valid = 1'b0;
        blk_x     = '0;
        blk_y     = '0;
        blk_coef  = '0;
        foreach (top_err[i, j]) begin
            top_err[i][j] = 0;
        end
        left_err[0] = 0;
        left_err[1] = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;

        // First row with the dead zone edge on the unfiltered sub-block 0
        for (int x = 0; x < 4; x++) begin
            fill_random();
            name = "first_row";
            if (x == 0) begin
                coef[0] = ZTH;
                coef[4] = -ZTH;
                name    = "deadzone_at";
            end
            run_block(name, x, 0);
        end
        for (int y = 1; y < 3; y++) begin
            for (int x = 0; x < 4; x++) begin
                fill_random();
                name = (x == 0) ? "top_only" : "interior";
                run_block(name, x, y);
            end
        end

        abort_block();
        fill_random();
        run_block("left_after_reset", 2, 0);
        fill_random();
        coef[0] = ZTH + 1;
        coef[4] = -(ZTH + 1);
        run_block("deadzone_above", 0, 0);
        fill_random();
        run_block("interior_after_reset", 1, 1);

        repeat (4) @(negedge clk);
        sva_fails = u_chroma_dc_quant_top.u_dc_error_corrector.u_sva.fail_cnt;
        $display("Checks %0d, value errors %0d, assertion failures %0d",
                 checks, errors, sva_fails);
        if (errors == 0 && sva_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Run stopped after %0d cycles without reaching the end", cycles);
        $display("test failed");
        $finish;
    end

endmodule

// File: chroma_dc_quant_sva.sv
// Concurrent checks on credit use, lane latency and the result pulse of the DC corrector
`timescale 1ns/1ns

module chroma_dc_quant_sva (
    input logic clk,
    input logic rst_n,
    input logic blk_valid_i,
    input logic done_i,
    input logic idle_i,
    input logic u_coef_valid_i,
    input logic u_res_valid_i,
    input logic v_coef_valid_i,
    input logic v_res_valid_i
);

    int unsigned fail_cnt = 0;
    logic        credit_q;

    // Sender credit that a block spends and done returns
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_q <= 1'b1;
        end else if (blk_valid_i) begin
            credit_q <= 1'b0;
        end else if (done_i) begin
            credit_q <= 1'b1;
        end
    end

    // ----------------------------------------
    // Properties
    // ----------------------------------------
    credit_held: assert property (@(posedge clk) disable iff (!rst_n)
        blk_valid_i |-> credit_q)
    else begin
        fail_cnt++;
        $error("Block sent without a credit");
    end

    accept_idle: assert property (@(posedge clk) disable iff (!rst_n)
        blk_valid_i |-> idle_i)
    else begin
        fail_cnt++;
        $error("Block arrived while another one was in flight");
    end

    // A second done cycle finds the credit already returned
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done_i |-> !credit_q)
    else begin
        fail_cnt++;
        $error("done without a block in flight or held for more than one cycle");
    end

    u_latency: assert property (@(posedge clk) disable iff (!rst_n)
        u_res_valid_i == $past(u_coef_valid_i, 2))
    else begin
        fail_cnt++;
        $error("U lane result not two cycles after its input");
    end

    v_latency: assert property (@(posedge clk) disable iff (!rst_n)
        v_res_valid_i == $past(v_coef_valid_i, 2))
    else begin
        fail_cnt++;
        $error("V lane result not two cycles after its input");
    end

endmodule

bind dc_error_corrector chroma_dc_quant_sva u_sva (
    .clk            (clk),
    .rst_n          (rst_n),
    .blk_valid_i    (blk_valid_i),
    .done_i         (done_o),
    .idle_i         (st[S_IDLE]),
    .u_coef_valid_i (qu.coef_valid),
    .u_res_valid_i  (qu.res_valid),
    .v_coef_valid_i (qv.coef_valid),
    .v_res_valid_i  (qv.res_valid)
);

// File: chroma_dc_quant_top.sv
// Chroma DC quantizer with error diffusion, top level
`timescale 1ns/1ns

module chroma_dc_quant_top
    import chroma_dc_pkg::*;
#(
    parameter int I_WIDTH = 12,
    parameter int O_WIDTH = 16,
    parameter int COL_W   = 10
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 blk_valid_i,
    input  logic [COL_W-1:0]     blk_x_i,
    input  logic [COL_W-1:0]     blk_y_i,
    input  logic [8*I_WIDTH-1:0] blk_coef_i,
    input  logic [Q_W-1:0]       q_i,
    input  logic [Q_W-1:0]       iq_i,
    input  logic [B_W-1:0]       bias_i,
    input  logic [B_W-1:0]       zthresh_i,
    output logic                 credit_o,
    output logic [8*O_WIDTH-1:0] levels_o,
    output logic [6*ERR_W-1:0]   derr_o,
    output logic                 done_o
);

    qs_if #(.W(O_WIDTH)) qs_u ();
    qs_if #(.W(O_WIDTH)) qs_v ();
    derr_if #(.COL_W(COL_W)) dl_if ();

    // One credit, returned with each result
    assign credit_o = done_o;

    dc_error_corrector #(
        .I_WIDTH (I_WIDTH),
        .O_WIDTH (O_WIDTH),
        .COL_W   (COL_W)
    ) u_dc_error_corrector (
        .clk         (clk),
        .rst_n       (rst_n),
        .blk_valid_i (blk_valid_i),
        .blk_x_i     (blk_x_i),
        .blk_y_i     (blk_y_i),
        .blk_coef_i  (blk_coef_i),
        .levels_o    (levels_o),
        .derr_o      (derr_o),
        .done_o      (done_o),
        .qu          (qs_u.corr),
        .qv          (qs_v.corr),
        .dl          (dl_if.corr)
    );

    derr_line_buffer #(.COL_W(COL_W)) u_derr_line_buffer (
        .clk   (clk),
        .rst_n (rst_n),
        .dl    (dl_if.lbuf)
    );

    quantize_single #(.O_WIDTH(O_WIDTH)) u_quantize_u (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_i       (q_i),
        .iq_i      (iq_i),
        .bias_i    (bias_i),
        .zthresh_i (zthresh_i),
        .qs        (qs_u.quant)
    );

    quantize_single #(.O_WIDTH(O_WIDTH)) u_quantize_v (
        .clk       (clk),
        .rst_n     (rst_n),
        .q_i       (q_i),
        .iq_i      (iq_i),
        .bias_i    (bias_i),
        .zthresh_i (zthresh_i),
        .qs        (qs_v.quant)
    );

endmodule

// File: dc_error_corrector.sv
// Sequencer that diffuses neighbour errors into the eight chroma DC values
`timescale 1ns/1ns

module dc_error_corrector
    import chroma_dc_pkg::*;
#(
    parameter int I_WIDTH = 12,
    parameter int O_WIDTH = 16,
    parameter int COL_W   = 10
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   blk_valid_i,
    input  logic [COL_W-1:0]       blk_x_i,
    input  logic [COL_W-1:0]       blk_y_i,
    input  logic [8*I_WIDTH-1:0]   blk_coef_i,
    output logic [8*O_WIDTH-1:0]   levels_o,
    output logic [6*ERR_W-1:0]     derr_o,
    output logic                   done_o,
    qs_if.corr                     qu,
    qs_if.corr                     qv,
    derr_if.corr                   dl
);

    localparam int S_IDLE = 0;
    localparam int S_RD   = 1;
    localparam int S_WT   = 2;
    localparam int S_BOTH = 3;
    localparam int S_TOP  = 4;
    localparam int S_LEFT = 5;
    localparam int S_NONE = 6;
    localparam int S_ST1  = 7;
    localparam int S_ST2  = 8;
    localparam int S_ST3  = 9;
    localparam int S_ST4  = 10;
    localparam int S_ST5  = 11;
    localparam int S_ST6  = 12;

    logic [12:0] st;
    logic [12:0] st_nxt;
    logic        accept;
    logic        mode;
    derr_word_u  top_sel;
    derr_word_u  left_sel;
    derr_word_u  top_r;
    derr_word_u  left_r;
    derr_word_u  wr_w;

    logic signed [I_WIDTH-1:0] coef_r [8];
    logic [COL_W-1:0]          x_r;
    logic signed [O_WIDTH-1:0] ul [3];
    logic signed [O_WIDTH-1:0] vl [3];
    logic signed [ERR_W-1:0]   ue [3];
    logic signed [ERR_W-1:0]   ve [3];

    // c + (7*top + 8*left) >>> 3
    function automatic logic signed [O_WIDTH-1:0] diffuse(
        input logic signed [I_WIDTH-1:0] c,
        input logic signed [ERR_W-1:0]   t,
        input logic signed [ERR_W-1:0]   l
    );
        logic signed [ERR_W+4:0] acc;
        acc = t * 7 + l * 8;
        return c + (acc >>> 3);
    endfunction

    // ----------------------------------------
    // One-hot sequencer
    // ----------------------------------------
    assign accept = st[S_IDLE] & blk_valid_i;
    assign mode   = st[S_BOTH] | st[S_TOP] | st[S_LEFT] | st[S_NONE];

    always_comb begin
        st_nxt = '0;
        case (1'b1)
            st[S_IDLE]: begin
                if (!blk_valid_i) begin
                    st_nxt[S_IDLE] = 1'b1;
                end else if (blk_y_i != '0) begin
                    st_nxt[S_RD] = 1'b1;
                end else if (blk_x_i != '0) begin
                    st_nxt[S_LEFT] = 1'b1;
                end else begin
                    st_nxt[S_NONE] = 1'b1;
                end
            end
            st[S_RD]:   st_nxt[S_WT] = 1'b1;
            st[S_WT]:   st_nxt[(x_r != '0) ? S_BOTH : S_TOP] = 1'b1;
            mode:       st_nxt[S_ST1] = 1'b1;
            st[S_ST1]:  st_nxt[S_ST2] = 1'b1;
            st[S_ST2]:  st_nxt[S_ST3] = 1'b1;
            st[S_ST3]:  st_nxt[S_ST4] = 1'b1;
            st[S_ST4]:  st_nxt[S_ST5] = 1'b1;
            st[S_ST5]:  st_nxt[S_ST6] = 1'b1;
            default:    st_nxt[S_IDLE] = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            st     <= 13'b1;
            done_o <= 1'b0;
        end else begin
            st     <= st_nxt;
            done_o <= st[S_ST6];
        end
    end

    // Missing neighbours count as zero
    assign top_sel  = (st[S_BOTH] | st[S_TOP]) ? dl.rd_word : '0;
    assign left_sel = (st[S_BOTH] | st[S_LEFT]) ? dl.left_word : '0;

    always_ff @(posedge clk) begin
        if (accept) begin
            for (int i = 0; i < 8; i++) begin
                coef_r[i] <= blk_coef_i[i*I_WIDTH +: I_WIDTH];
            end
            x_r <= blk_x_i;
        end
        if (mode) begin
            top_r  <= top_sel;
            left_r <= left_sel;
        end
        if (st[S_ST2]) begin
            ul[0] <= qu.level;
            vl[0] <= qv.level;
            ue[0] <= qu.err;
            ve[0] <= qv.err;
        end
        if (st[S_ST4]) begin
            ul[1] <= qu.level;
            vl[1] <= qv.level;
            ue[1] <= qu.err;
            ve[1] <= qv.err;
        end
        if (st[S_ST5]) begin
            ul[2] <= qu.level;
            vl[2] <= qv.level;
            ue[2] <= qu.err;
            ve[2] <= qv.err;
        end
    end

    // ----------------------------------------
    // Lane feed, U and V in parallel
    // ----------------------------------------
    always_comb begin
        qu.coef = '0;
        qv.coef = '0;
        case (1'b1)
            mode: begin
                qu.coef = diffuse(coef_r[0], top_sel.b[0], left_sel.b[0]);
                qv.coef = diffuse(coef_r[4], top_sel.b[2], left_sel.b[2]);
            end
            // Sub-block 1 takes the fresh error of sub-block 0 as its left
            st[S_ST2]: begin
                qu.coef = diffuse(coef_r[1], top_r.b[1], qu.err);
                qv.coef = diffuse(coef_r[5], top_r.b[3], qv.err);
            end
            st[S_ST3]: begin
                qu.coef = diffuse(coef_r[2], ue[0], left_r.b[1]);
                qv.coef = diffuse(coef_r[6], ve[0], left_r.b[3]);
            end
            st[S_ST5]: begin
                qu.coef = diffuse(coef_r[3], ue[1], qu.err);
                qv.coef = diffuse(coef_r[7], ve[1], qv.err);
            end
            default: ;
        endcase
    end

    assign qu.coef_valid = mode | st[S_ST2] | st[S_ST3] | st[S_ST5];
    assign qv.coef_valid = mode | st[S_ST2] | st[S_ST3] | st[S_ST5];

    // ----------------------------------------
    // Results and write back
    // ----------------------------------------
    assign levels_o = {qv.level, vl[2], vl[1], vl[0], qu.level, ul[2], ul[1], ul[0]};
    assign derr_o   = {qv.err, ve[2], ve[1], qu.err, ue[2], ue[1]};

    // Bottom row errors go to the line buffer
    always_comb begin
        wr_w.b[0] = ue[2];
        wr_w.b[1] = qu.err;
        wr_w.b[2] = ve[2];
        wr_w.b[3] = qv.err;
    end

    assign dl.rd_en   = st[S_RD];
    assign dl.rd_addr = x_r;
    assign dl.wr_en   = done_o;
    assign dl.wr_addr = x_r;
    assign dl.wr_word = wr_w;

endmodule

// File: derr_line_buffer.sv
// Top error store per macroblock column and left error register
`timescale 1ns/1ns

module derr_line_buffer
    import chroma_dc_pkg::*;
#(
    parameter int COL_W = 10
) (
    input  logic clk,
    input  logic rst_n,
    derr_if.lbuf dl
);

    localparam int DEPTH = 2 ** COL_W;

    derr_word_u mem [DEPTH];
    derr_word_u left_q;

    // Registered read, held until the next read
    always_ff @(posedge clk) begin
        if (dl.rd_en) begin
            dl.rd_word <= mem[dl.rd_addr];
        end
        if (dl.wr_en) begin
            mem[dl.wr_addr] <= dl.wr_word;
        end
    end

    // ----------------------------------------
    // Left errors for the next block
    // ----------------------------------------
    // Right column error of each plane feeds both left positions
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            left_q <= '0;
        end else if (dl.wr_en) begin
            left_q.h.u_pair <= {2{dl.wr_word.h.u_pair[2*ERR_W-1:ERR_W]}};
            left_q.h.v_pair <= {2{dl.wr_word.h.v_pair[2*ERR_W-1:ERR_W]}};
        end
    end

    assign dl.left_word = left_q;

endmodule

// File: quantize_single.sv
// Two stage scalar quantizer giving the DC level and its diffusion error
`timescale 1ns/1ns

module quantize_single
    import chroma_dc_pkg::*;
#(
    parameter int O_WIDTH = 16
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic [Q_W-1:0] q_i,
    input  logic [Q_W-1:0] iq_i,
    input  logic [B_W-1:0] bias_i,
    input  logic [B_W-1:0] zthresh_i,
    qs_if.quant            qs
);

    logic               s1_valid;
    logic               s1_sign;
    logic               s1_over;
    logic [O_WIDTH-1:0] s1_mag;

    logic [O_WIDTH-1:0]        abs_c;
    logic [B_W:0]              sum;
    logic [B_W:0]              lvl_full;
    logic [O_WIDTH-1:0]        lvl_mag;
    logic signed [O_WIDTH:0]   diff;
    logic signed [O_WIDTH:0]   serr;

    assign abs_c = qs.coef[O_WIDTH-1] ? O_WIDTH'(-qs.coef) : qs.coef;

    // ----------------------------------------
    // Stage 1  sign, magnitude, dead zone
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= qs.coef_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (qs.coef_valid) begin
            s1_sign <= qs.coef[O_WIDTH-1];
            s1_mag  <= abs_c;
            s1_over <= abs_c > zthresh_i;
        end
    end

    // ----------------------------------------
    // Stage 2  scale, rescale, error
    // ----------------------------------------
    assign sum      = s1_mag * iq_i + bias_i;
    assign lvl_full = (sum >> QFIX) * q_i;
    assign lvl_mag  = s1_over ? lvl_full[O_WIDTH-1:0] : '0;
    // Inside the dead zone the level is zero, so the error is the value itself
    assign diff     = $signed({1'b0, s1_mag}) - $signed({1'b0, lvl_mag});
    assign serr     = s1_sign ? -diff : diff;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qs.res_valid <= 1'b0;
        end else begin
            qs.res_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            qs.level <= s1_sign ? -$signed(lvl_mag) : $signed(lvl_mag);
            qs.err   <= ERR_W'(serr >>> 1);
        end
    end

endmodule

// File: derr_if.sv
// Link between the error corrector and the diffusion error line buffer
`timescale 1ns/1ns

interface derr_if
    import chroma_dc_pkg::*;
#(
    parameter int COL_W = 10
) ();

    logic             rd_en;
    logic [COL_W-1:0] rd_addr;
    logic             wr_en;
    logic [COL_W-1:0] wr_addr;
    derr_word_u       wr_word;
    derr_word_u       rd_word;
    derr_word_u       left_word;

    modport corr (output rd_en, rd_addr, wr_en, wr_addr, wr_word, input rd_word, left_word);
    modport lbuf (input rd_en, rd_addr, wr_en, wr_addr, wr_word, output rd_word, left_word);

endinterface

// File: qs_if.sv
// Link between the error corrector and one scalar quantizer lane
`timescale 1ns/1ns

interface qs_if
    import chroma_dc_pkg::*;
#(
    parameter int W = 16
) ();

    logic signed [W-1:0]     coef;
    logic                    coef_valid;
    logic signed [W-1:0]     level;
    logic signed [ERR_W-1:0] err;
    logic                    res_valid;

    modport corr (output coef, coef_valid, input level, err, res_valid);
    modport quant (input coef, coef_valid, output level, err, res_valid);

endinterface

// File: chroma_dc_pkg.sv
// Chroma DC quantizer shared widths, quantizer shift and error word layout
package chroma_dc_pkg;

    // ----------------------------------------
    // Fixed widths
    // ----------------------------------------
    // Quantizer right shift after multiply-add
    localparam int QFIX  = 17;
    // One diffusion error
    localparam int ERR_W = 8;
    // Quantizer matrix terms q and iq
    localparam int Q_W   = 16;
    // Bias and zero threshold
    localparam int B_W   = 32;

    // ----------------------------------------
    // Stored error word
    // ----------------------------------------
    // Per plane: low byte is the left column error, high byte the right column error
    typedef struct packed {
        logic [2*ERR_W-1:0] v_pair;
        logic [2*ERR_W-1:0] u_pair;
    } derr_pair_s;

    // Byte view  b[0] U left, b[1] U right, b[2] V left, b[3] V right
    typedef union packed {
        logic [3:0][ERR_W-1:0] b;
        derr_pair_s            h;
    } derr_word_u;

endpackage
